// ==== sources.f ====
rtl/dsp_types_pkg.sv
rtl/dsp_isa_pkg.sv
rtl/block_program.sv
rtl/block_sequencer.sv
rtl/madd_unit.sv
rtl/channel_file.sv
rtl/dsp_core.sv
tb/dsp_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module dsp_core_tb -f sources.f \
	-o dsp_core_sim > build.log 2>&1 && ./obj_dir/dsp_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" && exit 0 || echo "FAIL"
exit 1

// ==== tb/dsp_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_core_tb;
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;

	localparam int n_rows = 21;
	localparam int busy_limit = 4 * (n_blocks + 1);
	localparam longint watchdog_ns = 10 * (longint'(n_rows) * (4 * 257 + 20) + 40);

	logic clk;
	logic reset;
	logic tick;
	sample_t sample_in;
	wire sample_t sample_out;
	logic command_instr_write;
	logic command_reg_write;
	block_addr_t command_block_target;
	logic command_reg_target;
	instr_t command_instr_write_val;
	sample_t command_reg_write_val;
	wire busy;

	// Frame table
	// Program id -1 means nothing is loaded
	int row_prog [n_rows];
	sample_t row_gain [n_rows];
	sample_t row_cval [n_rows];
	sample_t row_sample [n_rows];
	sample_t row_expect [n_rows];
	int row_busy [n_rows];

	// Reference model of the program store and channels
	instr_t m_instr [4];
	sample_t m_reg0 [4];
	sample_t m_reg1 [4];
	sample_t m_chan [n_channels];
	int m_last;
	logic m_loaded;
	int errors;

	dsp_core dsp_core_i (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.command_instr_write(command_instr_write),
		.command_reg_write(command_reg_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val),
		.busy(busy)
	);

	always #5 clk = ~clk;

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run went past its time limit");
		$display("tests failed");
		$fatal(1);
	end

	function automatic instr_t make_instr(logic active, int src_a, int src_c, int dest,
			int shift, logic b_reg, logic c_reg);
		instr_t w;
		w = '0;
		w[src_a_lsb +: 4] = src_a[3:0];
		w[src_c_lsb +: 4] = src_c[3:0];
		w[dest_lsb +: 4] = dest[3:0];
		w[shift_lsb +: 2] = shift[1:0];
		w[b_from_reg_bit] = b_reg;
		w[c_from_reg_bit] = c_reg;
		w[active_bit] = active;
		return w;
	endfunction

	// a * b * 2^shift + c * 2^15 clamped and cut to bits 30..15
	function automatic sample_t madd_model(sample_t a, sample_t b, sample_t c, int shift);
		longint acc;
		acc = longint'(a) * longint'(b);
		acc = acc * (64'sd1 << shift);
		acc = acc + longint'(c) * 64'sd32768;
		if (acc > 64'sd1073741823)
			acc = 64'sd1073741823;
		else if (acc < -64'sd1073741824)
			acc = -64'sd1073741824;
		return sample_t'(acc >>> 15);
	endfunction

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic build_table;
		for (int r = 0; r < n_rows; r++) begin
			row_sample[r] = sample_t'($urandom) >>> 2;
			row_cval[r] = '0;
			row_gain[r] = 16'sh2000;
			if (r == 0) begin
				row_prog[r] = -1;
			end else if (r < 5) begin
				row_prog[r] = 0;
				row_gain[r] = 16'sh4000;
			end else if (r < 9) begin
				row_prog[r] = 1;
				row_gain[r] = 16'sh7fff;
				// Magnitude of at least 0x4000 pushes the product into the clamp
				row_sample[r] = sample_t'($urandom);
				row_sample[r][14] = ~row_sample[r][15];
				row_cval[r] = row_sample[r][15] ? 16'sh9000 : 16'sh7000;
			end else if (r < 13) begin
				row_prog[r] = 2;
			end else if (r < 17) begin
				row_prog[r] = 2;
				row_gain[r] = 16'sh6000;
			end else begin
				row_prog[r] = 3;
			end
		end
	endtask

	task automatic write_block(input int blk, input instr_t w, input sample_t r0,
			input sample_t r1, input logic to_dut);
		m_instr[blk] = w;
		m_reg0[blk] = r0;
		m_reg1[blk] = r1;
		if (blk >= m_last) begin
			m_last = blk;
			m_loaded = 1'b1;
		end
		if (to_dut) begin
			@(negedge clk);
			command_block_target = block_addr_t'(blk);
			command_instr_write_val = w;
			command_instr_write = 1'b1;
			@(negedge clk);
			command_instr_write = 1'b0;
			command_reg_write = 1'b1;
			command_reg_target = 1'b0;
			command_reg_write_val = r0;
			@(negedge clk);
			command_reg_target = 1'b1;
			command_reg_write_val = r1;
			@(negedge clk);
			command_reg_write = 1'b0;
		end
	endtask

	task automatic load_program(input int r, input logic to_dut);
		case (row_prog[r])
			0, 1: begin
				write_block(0, make_instr(1'b1, 0, 0, 0, (row_prog[r] == 0) ? 1 : 3, 1'b1, 1'b1),
					row_gain[r], row_cval[r], to_dut);
			end
			2, 3: begin
				// Delay line
				// Block 1 becomes a no-op in program 3
				write_block(0, make_instr(1'b1, 1, 0, 2, 1, 1'b1, 1'b1), 16'sh4000, '0, to_dut);
				write_block(1, make_instr(row_prog[r] == 2, 0, 0, 1, 1, 1'b1, 1'b1), 16'sh4000, '0,
					to_dut);
				write_block(2, make_instr(1'b1, 0, 2, 0, 0, 1'b1, 1'b0), row_gain[r], '0, to_dut);
			end
			default: begin
			end
		endcase
	endtask

	task automatic model_frame(input int r);
		instr_t w;
		sample_t a;
		sample_t b;
		sample_t c;
		row_expect[r] = m_chan[0];
		m_chan[0] = row_sample[r];
		row_busy[r] = m_loaded ? 4 * (m_last + 1) : 0;
		if (m_loaded) begin
			for (int blk = 0; blk <= m_last; blk++) begin
				w = m_instr[blk];
				a = m_chan[w[src_a_lsb +: 4]];
				b = w[b_from_reg_bit] ? m_reg0[blk] : m_chan[w[src_b_lsb +: 4]];
				c = w[c_from_reg_bit] ? m_reg1[blk] : m_chan[w[src_c_lsb +: 4]];
				if (w[active_bit])
					m_chan[w[dest_lsb +: 4]] = madd_model(a, b, c, int'(w[shift_lsb +: 2]));
			end
		end
	endtask

	task automatic run_frame(input int r);
		int cycles;
		cycles = 0;
		while (busy !== 1'b0) begin
			if (cycles >= busy_limit) begin
				$display("busy stayed high before the tick of frame %0d", r);
				$display("tests failed");
				$fatal(1);
			end
			@(negedge clk);
			cycles++;
		end
		sample_in = row_sample[r];
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		cycles = 0;
		while (busy === 1'b1) begin
			if (cycles >= busy_limit) begin
				$display("busy did not fall within %0d cycles in frame %0d", busy_limit, r);
				$display("tests failed");
				$fatal(1);
			end
			// A second tick inside the frame must be dropped
			tick = (cycles == 1);
			@(negedge clk);
			cycles++;
		end
		tick = 1'b0;
		@(negedge clk);
		check_value("busy cycles", cycles, row_busy[r]);
		check_value("sample_out", sample_out, row_expect[r]);
	endtask

	task automatic clear_model;
		for (int i = 0; i < n_channels; i++)
			m_chan[i] = '0;
		m_last = 0;
		m_loaded = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_instr_write = 1'b0;
		command_reg_write = 1'b0;
		command_block_target = '0;
		command_reg_target = 1'b0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		errors = 0;
		void'($urandom(32'hafa6));

		build_table();
		clear_model();
		for (int r = 0; r < n_rows; r++) begin
			load_program(r, 1'b0);
			model_frame(r);
		end
		clear_model();

		repeat (10) @(negedge clk);
		reset = 1'b0;

		for (int r = 0; r < n_rows; r++) begin
			load_program(r, 1'b1);
			run_frame(r);
		end

		if (errors == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dsp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_core (
	input wire clk,
	input wire reset,

	input wire tick,
	input wire dsp_types_pkg::sample_t sample_in,
	output wire dsp_types_pkg::sample_t sample_out,

	input wire command_instr_write,
	input wire command_reg_write,
	input wire dsp_types_pkg::block_addr_t command_block_target,
	input wire command_reg_target,
	input wire dsp_isa_pkg::instr_t command_instr_write_val,
	input wire dsp_types_pkg::sample_t command_reg_write_val,

	output wire busy
);
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;

	wire block_addr_t block_addr;
	wire block_addr_t last_block;
	wire program_loaded;
	wire instr_t instr;
	wire sample_t reg0;
	wire sample_t reg1;

	wire issue;
	wire done;
	wire frame_start;

	wire chan_addr_t rd_addr_a;
	wire chan_addr_t rd_addr_b;
	wire chan_addr_t rd_addr_c;
	wire sample_t rd_a;
	wire sample_t rd_b;
	wire sample_t rd_c;

	wire write_enable;
	wire chan_addr_t write_addr;
	wire sample_t write_value;

	block_program program_i (
		.clk(clk),
		.reset(reset),
		.command_instr_write(command_instr_write),
		.command_reg_write(command_reg_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val),
		.block_addr(block_addr),
		.instr(instr),
		.reg0(reg0),
		.reg1(reg1),
		.last_block(last_block),
		.program_loaded(program_loaded)
	);

	block_sequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.last_block(last_block),
		.program_loaded(program_loaded),
		.done(done),
		.block_addr(block_addr),
		.issue(issue),
		.frame_start(frame_start),
		.busy(busy)
	);

	madd_unit madd_i (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.instr(instr),
		.reg0(reg0),
		.reg1(reg1),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_addr_c(rd_addr_c),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_c(rd_c),
		.write_enable(write_enable),
		.write_addr(write_addr),
		.write_value(write_value),
		.done(done)
	);

	channel_file channels_i (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_addr_c(rd_addr_c),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_c(rd_c),
		.write_enable(write_enable),
		.write_addr(write_addr),
		.write_value(write_value)
	);

endmodule

`default_nettype wire

// ==== rtl/channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_file (
	input wire clk,
	input wire reset,

	input wire frame_start,
	input wire dsp_types_pkg::sample_t sample_in,
	output dsp_types_pkg::sample_t sample_out,

	input wire dsp_types_pkg::chan_addr_t rd_addr_a,
	input wire dsp_types_pkg::chan_addr_t rd_addr_b,
	input wire dsp_types_pkg::chan_addr_t rd_addr_c,
	output dsp_types_pkg::sample_t rd_a,
	output dsp_types_pkg::sample_t rd_b,
	output dsp_types_pkg::sample_t rd_c,

	input wire write_enable,
	input wire dsp_types_pkg::chan_addr_t write_addr,
	input wire dsp_types_pkg::sample_t write_value
);
	import dsp_types_pkg::*;

	sample_t channels [n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
			sample_out <= '0;
		end else begin
			// Channel 0 is the sample port
			if (frame_start) begin
				sample_out <= channels[0];
				channels[0] <= sample_in;
			end

			if (write_enable)
				channels[write_addr] <= write_value;
		end
	end

	// Writes of earlier blocks land before the next block reads
	always_ff @(posedge clk) begin
		rd_a <= channels[rd_addr_a];
		rd_b <= channels[rd_addr_b];
		rd_c <= channels[rd_addr_c];
	end

endmodule

`default_nettype wire

// ==== rtl/madd_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module madd_unit (
	input wire clk,
	input wire reset,

	input wire issue,
	input wire dsp_isa_pkg::instr_t instr,
	input wire dsp_types_pkg::sample_t reg0,
	input wire dsp_types_pkg::sample_t reg1,

	output dsp_types_pkg::chan_addr_t rd_addr_a,
	output dsp_types_pkg::chan_addr_t rd_addr_b,
	output dsp_types_pkg::chan_addr_t rd_addr_c,
	input wire dsp_types_pkg::sample_t rd_a,
	input wire dsp_types_pkg::sample_t rd_b,
	input wire dsp_types_pkg::sample_t rd_c,

	output logic write_enable,
	output dsp_types_pkg::chan_addr_t write_addr,
	output dsp_types_pkg::sample_t write_value,
	output logic done
);
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;

	logic pending;
	logic active_q;
	logic b_from_reg_q;
	logic c_from_reg_q;
	shift_t shift_q;
	chan_addr_t dest_q;
	sample_t reg0_q;
	sample_t reg1_q;

	sample_t op_b;
	sample_t op_c;
	full_t prod;
	full_t c_ext;
	full_t sum;
	full_t sat;

	assign rd_addr_a = instr_src_a(instr);
	assign rd_addr_b = instr_src_b(instr);
	assign rd_addr_c = instr_src_c(instr);

	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else
			pending <= issue;
	end

	// Fields held while the channel reads complete
	always_ff @(posedge clk) begin
		if (issue) begin
			active_q <= instr_active(instr);
			b_from_reg_q <= instr_b_from_reg(instr);
			c_from_reg_q <= instr_c_from_reg(instr);
			shift_q <= instr_shift(instr);
			dest_q <= instr_dest(instr);
			reg0_q <= reg0;
			reg1_q <= reg1;
		end
	end

	assign op_b = b_from_reg_q ? reg0_q : rd_b;
	assign op_c = c_from_reg_q ? reg1_q : rd_c;

	// Operands sign extend to the full width before the multiply
	assign prod = rd_a * op_b;
	assign c_ext = op_c;
	assign sum = (prod <<< shift_q) + (c_ext <<< frac_bits);

	always_comb begin
		if (sum > sat_max)
			sat = sat_max;
		else if (sum < sat_min)
			sat = sat_min;
		else
			sat = sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_enable <= 1'b0;
			done <= 1'b0;
		end else begin
			write_enable <= pending && active_q;
			done <= pending;
		end
	end

	always_ff @(posedge clk) begin
		if (pending) begin
			write_addr <= dest_q;
			write_value <= sat[frac_bits + data_width - 1 : frac_bits];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/block_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_sequencer (
	input wire clk,
	input wire reset,

	input wire tick,
	input wire dsp_types_pkg::block_addr_t last_block,
	input wire program_loaded,
	input wire done,

	output dsp_types_pkg::block_addr_t block_addr,
	output logic issue,
	output logic frame_start,
	output logic busy
);

	typedef enum logic [1 : 0] {
		idle,
		fetch,
		execute,
		wait_done
	} state_t;

	state_t state;

	// One block per 4 cycles of address, instruction, operands and writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			block_addr <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;

			case (state)
				idle: begin
					// Sample exchange happens even with no program
					if (tick) begin
						frame_start <= 1'b1;
						block_addr <= '0;
						if (program_loaded)
							state <= fetch;
					end
				end

				fetch: begin
					state <= execute;
				end

				execute: begin
					state <= wait_done;
				end

				wait_done: begin
					if (done) begin
						if (block_addr == last_block) begin
							state <= idle;
						end else begin
							block_addr <= block_addr + 1'b1;
							state <= fetch;
						end
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// Instruction and block registers are valid in execute
	assign issue = (state == execute);

	// Ticks arriving while busy are dropped
	assign busy = (state != idle);

endmodule

`default_nettype wire

// ==== rtl/block_program.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_program (
	input wire clk,
	input wire reset,

	input wire command_instr_write,
	input wire command_reg_write,
	input wire dsp_types_pkg::block_addr_t command_block_target,
	input wire command_reg_target,
	input wire dsp_isa_pkg::instr_t command_instr_write_val,
	input wire dsp_types_pkg::sample_t command_reg_write_val,

	input wire dsp_types_pkg::block_addr_t block_addr,
	output dsp_isa_pkg::instr_t instr,
	output dsp_types_pkg::sample_t reg0,
	output dsp_types_pkg::sample_t reg1,

	output dsp_types_pkg::block_addr_t last_block,
	output logic program_loaded
);
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;

	instr_t instr_mem [n_blocks];
	sample_t reg0_mem [n_blocks];
	sample_t reg1_mem [n_blocks];

	always_ff @(posedge clk) begin
		if (command_instr_write)
			instr_mem[command_block_target] <= command_instr_write_val;

		if (command_reg_write) begin
			if (command_reg_target)
				reg1_mem[command_block_target] <= command_reg_write_val;
			else
				reg0_mem[command_block_target] <= command_reg_write_val;
		end
	end

	// Block fetch for the sequencer
	always_ff @(posedge clk) begin
		instr <= instr_mem[block_addr];
		reg0 <= reg0_mem[block_addr];
		reg1 <= reg1_mem[block_addr];
	end

	// Highest block written since reset sets the program length
	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
			program_loaded <= 1'b0;
		end else if (command_instr_write && command_block_target >= last_block) begin
			last_block <= command_block_target;
			program_loaded <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dsp_isa_pkg.sv ====
`default_nettype none

package dsp_isa_pkg;

	typedef logic [31 : 0] instr_t;
	typedef logic [1 : 0] shift_t;

	localparam int chan_field_w = $bits(dsp_types_pkg::chan_addr_t);
	localparam int shift_field_w = $bits(shift_t);

	// Field positions in the instruction word
	localparam int src_a_lsb = 0;
	localparam int src_b_lsb = 4;
	localparam int src_c_lsb = 8;
	localparam int dest_lsb = 12;
	localparam int shift_lsb = 16;
	localparam int b_from_reg_bit = 18;
	localparam int c_from_reg_bit = 19;
	localparam int active_bit = 20;

	function automatic dsp_types_pkg::chan_addr_t instr_src_a(instr_t w);
		return w[src_a_lsb +: chan_field_w];
	endfunction

	function automatic dsp_types_pkg::chan_addr_t instr_src_b(instr_t w);
		return w[src_b_lsb +: chan_field_w];
	endfunction

	function automatic dsp_types_pkg::chan_addr_t instr_src_c(instr_t w);
		return w[src_c_lsb +: chan_field_w];
	endfunction

	function automatic dsp_types_pkg::chan_addr_t instr_dest(instr_t w);
		return w[dest_lsb +: chan_field_w];
	endfunction

	function automatic shift_t instr_shift(instr_t w);
		return w[shift_lsb +: shift_field_w];
	endfunction

	function automatic logic instr_b_from_reg(instr_t w);
		return w[b_from_reg_bit];
	endfunction

	function automatic logic instr_c_from_reg(instr_t w);
		return w[c_from_reg_bit];
	endfunction

	// Clear means the block is a no-op
	function automatic logic instr_active(instr_t w);
		return w[active_bit];
	endfunction

endpackage

`default_nettype wire

// ==== rtl/dsp_types_pkg.sv ====
`default_nettype none

package dsp_types_pkg;

	localparam int data_width = 16;
	localparam int n_blocks = 256;
	localparam int n_channels = 16;

	// Q15 samples
	localparam int frac_bits = 15;

	// Full product plus headroom for the gain shift and the added term
	localparam int full_width = 2 * data_width + 8;

	typedef logic signed [data_width - 1 : 0] sample_t;
	typedef logic signed [full_width - 1 : 0] full_t;
	typedef logic [$clog2(n_blocks) - 1 : 0] block_addr_t;
	typedef logic [$clog2(n_channels) - 1 : 0] chan_addr_t;

	// Clamp range before the Q15 result is taken from bits 30..15
	localparam full_t sat_max = (full_t'(1) <<< (2 * data_width - 2)) - 1;
	localparam full_t sat_min = -(full_t'(1) <<< (2 * data_width - 2));

endpackage

`default_nettype wire
